// ==== logic/reg_access_pkg.sv ====
// Widths, register numbers and encodings for the register access stage
// Size step and byte alias helpers
`default_nettype none

package reg_access_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] seg_t;
    typedef logic [2:0]  reg_idx_t;
    // Bit 1 pop, bit 0 push
    typedef logic [1:0]  stack_op_t;

    typedef enum logic [1:0] {
        size_byte  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } opsize_e;

    typedef enum logic [2:0] {
        op_none     = 3'd0,
        op_reg      = 3'd1,
        op_seg      = 3'd2,
        op_imm      = 3'd3,
        op_modrm_rm = 3'd4,
        op_mem      = 3'd5
    } opkind_e;

    localparam int NUM_GPR = 8;
    localparam int NUM_SEG = 6;

    localparam reg_idx_t ESP_IDX = 3'd4;
    localparam reg_idx_t ESI_IDX = 3'd6;
    localparam reg_idx_t EDI_IDX = 3'd7;

    function automatic word_t size_step(opsize_e size);
        case (size)
            size_byte: return 32'd1;
            size_word: return 32'd2;
            default:   return 32'd4;
        endcase
    endfunction

    // Byte access to 4..7 means AH..BH, held in registers 0..3
    function automatic reg_idx_t alias_base(reg_idx_t idx, opsize_e size);
        if (size == size_byte && idx[2]) begin
            return {1'b0, idx[1:0]};
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// ==== logic/gpr_write_if.sv ====
// Request/grant write lane into the general register file
`default_nettype none

interface gpr_write_if
    import reg_access_pkg::*;
();

    logic     req;
    logic     gnt;
    reg_idx_t idx;
    opsize_e  size;
    word_t    data;

    modport requester (
        output req, idx, size, data,
        input  gnt
    );

    modport arbiter (
        input  req, idx, size, data,
        output gnt
    );

endinterface

`default_nettype wire

// ==== logic/gpr_write_arbiter.sv ====
// Fixed-priority arbiter for the general register file write port
// Lane 0 has the highest priority
`default_nettype none

module gpr_write_arbiter
    import reg_access_pkg::*;
#(
    parameter int NUM_LANES = 3
) (
    gpr_write_if.arbiter lanes [NUM_LANES],
    output logic         wr_en,
    output reg_idx_t     wr_idx,
    output opsize_e      wr_size,
    output word_t        wr_data
);

    localparam int SEL_W = $clog2(NUM_LANES);

    logic [NUM_LANES-1:0] req_vec;
    logic [NUM_LANES-1:0] gnt_vec;
    reg_idx_t             idx_arr  [NUM_LANES];
    opsize_e              size_arr [NUM_LANES];
    word_t                data_arr [NUM_LANES];
    logic [SEL_W-1:0]     sel;

    // Flatten the lanes so the winner can be picked by index
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign req_vec[i]   = lanes[i].req;
        assign idx_arr[i]   = lanes[i].idx;
        assign size_arr[i]  = lanes[i].size;
        assign data_arr[i]  = lanes[i].data;
        assign lanes[i].gnt = gnt_vec[i];
    end

    // Isolate the lowest set request bit
    assign gnt_vec = req_vec & ~(req_vec - 1'b1);

    always_comb begin
        sel = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    assign wr_en   = |req_vec;
    assign wr_idx  = idx_arr[sel];
    assign wr_size = size_arr[sel];
    assign wr_data = data_arr[sel];

endmodule

`default_nettype wire

// ==== logic/gpr_file.sv ====
// Eight general registers, one size-aware write port
// Two operand read ports plus fixed ESP, ESI and EDI outputs
`default_nettype none

module gpr_file
    import reg_access_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  opsize_e  wr_size,
    input  word_t    wr_data,
    input  reg_idx_t rd0_idx,
    input  reg_idx_t rd1_idx,
    output word_t    rd0_data,
    output word_t    rd1_data,
    output word_t    esp,
    output word_t    esi,
    output word_t    edi
);

    word_t    regs [NUM_GPR];
    reg_idx_t wr_base;

    assign wr_base = alias_base(wr_idx, wr_size);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            case (wr_size)
                size_dword: begin
                    regs[wr_base] <= wr_data;
                end
                size_word: begin
                    regs[wr_base][15:0] <= wr_data[15:0];
                end
                size_byte: begin
                    // AH, CH, DH, BH
                    if (wr_idx[2]) begin
                        regs[wr_base][15:8] <= wr_data[7:0];
                    end else begin
                        regs[wr_base][7:0] <= wr_data[7:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign rd0_data = regs[rd0_idx];
    assign rd1_data = regs[rd1_idx];
    assign esp      = regs[ESP_IDX];
    assign esi      = regs[ESI_IDX];
    assign edi      = regs[EDI_IDX];

endmodule

`default_nettype wire

// ==== logic/seg_file.sv ====
// Six segment registers with writeback and direct CS write
`default_nettype none

module seg_file
    import reg_access_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  seg_t     wr_data,
    input  logic     write_cs_enable,
    input  seg_t     write_cs,
    input  reg_idx_t rd_idx,
    output seg_t     rd_data,
    output seg_t     ss
);

    // Order is ES, CS, SS, DS, FS, GS
    localparam reg_idx_t CS_IDX = 3'd1;
    localparam reg_idx_t SS_IDX = 3'd2;

    seg_t segs [NUM_SEG];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SEG; i++) begin
                segs[i] <= '0;
            end
        end else begin
            if (wr_en && wr_idx < NUM_SEG) begin
                segs[wr_idx] <= wr_data;
            end
            // Far jump CS load overrides writeback
            if (write_cs_enable) begin
                segs[CS_IDX] <= write_cs;
            end
        end
    end

    assign rd_data = (rd_idx < NUM_SEG) ? segs[rd_idx] : '0;
    assign ss      = segs[SS_IDX];

endmodule

`default_nettype wire

// ==== logic/reg_scoreboard.sv ====
// Pending-write bits for the general registers
// Read-after-write stall for operands and the stack pointer
`default_nettype none

module reg_scoreboard
    import reg_access_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     accept,
    input  logic     writes_op0,
    input  reg_idx_t op0_reg,
    input  reg_idx_t op1_reg,
    input  opsize_e  size,
    input  logic     stack_use,
    input  logic     wb_en,
    input  reg_idx_t wb_idx,
    input  opsize_e  wb_size,
    output logic     stall
);

    logic [NUM_GPR-1:0] pending;
    logic [NUM_GPR-1:0] set_mask;
    logic [NUM_GPR-1:0] clr_mask;
    reg_idx_t           op0_base;
    reg_idx_t           op1_base;
    reg_idx_t           wb_base;

    assign op0_base = alias_base(op0_reg, size);
    assign op1_base = alias_base(op1_reg, size);
    assign wb_base  = alias_base(wb_idx, wb_size);

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (accept && writes_op0) begin
            set_mask[op0_base] = 1'b1;
        end
        if (wb_en) begin
            clr_mask[wb_base] = 1'b1;
        end
    end

    // A new claim beats a retiring write to the same register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

    assign stall = pending[op0_base] || pending[op1_base] ||
                   (stack_use && pending[ESP_IDX]);

endmodule

`default_nettype wire

// ==== logic/stack_tracker.sv ====
// Speculative ESP and push/pop stack address
// Architectural ESP update through the commit write lane
`default_nettype none

module stack_tracker
    import reg_access_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      accept,
    input  stack_op_t stack_op,
    input  opsize_e   size,
    input  logic      wb_reg_en,
    input  logic      wb_stack,
    input  reg_idx_t  wb_reg_number,
    input  word_t     wb_reg_data,
    input  logic      wb_stack_en,
    input  stack_op_t wb_stack_op,
    input  opsize_e   wb_stack_size,
    input  word_t     esp,
    input  seg_t      ss,
    output logic      commit_hold,
    output word_t     stack_address,
    gpr_write_if.requester commit
);

    word_t     spec_esp;
    word_t     step;
    word_t     push_esp;
    logic      spec_reload;
    logic      commit_req;
    stack_op_t commit_op;
    opsize_e   commit_size;
    word_t     commit_step;

    assign step        = size_step(size);
    assign push_esp    = spec_esp - step;
    assign spec_reload = wb_reg_en && !wb_stack && wb_reg_number == ESP_IDX;

    // Pop reads the current top, push the slot below it
    assign stack_address = {16'b0, ss} + (stack_op[1] ? spec_esp : push_esp);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spec_esp <= '0;
        end else if (spec_reload) begin
            spec_esp <= wb_reg_data;
        end else if (accept && stack_op[1]) begin
            spec_esp <= spec_esp + step;
        end else if (accept && stack_op[0]) begin
            spec_esp <= push_esp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_req <= 1'b0;
        end else if (wb_stack_en) begin
            commit_req <= 1'b1;
        end else if (commit.gnt) begin
            commit_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_stack_en) begin
            commit_op   <= wb_stack_op;
            commit_size <= wb_stack_size;
        end
    end

    assign commit_step = size_step(commit_size);

    assign commit.req  = commit_req;
    assign commit.idx  = ESP_IDX;
    assign commit.size = size_dword;
    assign commit.data = commit_op[1] ? esp + commit_step : esp - commit_step;

    // Waiting on a higher-priority writer
    assign commit_hold = commit_req && !commit.gnt;

endmodule

`default_nettype wire

// ==== logic/string_pointer_unit.sv ====
// MOVS pointer step, ESI then EDI through one shared write lane
`default_nettype none

module string_pointer_unit
    import reg_access_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  logic    flag_df,
    input  opsize_e size,
    input  word_t   esi,
    input  word_t   edi,
    output logic    busy,
    gpr_write_if.requester lane
);

    typedef enum logic [1:0] {
        idle,
        write_esi,
        write_edi
    } state_e;

    state_e  state;
    logic    df_q;
    opsize_e size_q;
    word_t   ptr;
    word_t   step;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= write_esi;
                    end
                end
                write_esi: begin
                    if (lane.gnt) begin
                        state <= write_edi;
                    end
                end
                write_edi: begin
                    if (lane.gnt) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == idle) begin
            df_q   <= flag_df;
            size_q <= size;
        end
    end

    // One adder shared by both pointers, DF set walks downward
    assign step = size_step(size_q);
    assign ptr  = (state == write_edi) ? edi : esi;

    assign lane.req  = state != idle;
    assign lane.idx  = (state == write_edi) ? EDI_IDX : ESI_IDX;
    assign lane.size = size_dword;
    assign lane.data = df_q ? ptr - step : ptr + step;

    assign busy = state != idle;

endmodule

`default_nettype wire

// ==== logic/reg_access_top.sv ====
// Register access stage top level
// Operand register selection, stage handshake and unit instances
`default_nettype none

module reg_access_top
    import reg_access_pkg::*;
#(
    parameter int NUM_LANES = 3
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      d_valid,
    output logic      d_ready,
    input  opsize_e   d_size,
    input  opkind_e   d_op0,
    input  opkind_e   d_op1,
    input  reg_idx_t  d_op0_reg,
    input  reg_idx_t  d_op1_reg,
    input  reg_idx_t  d_modrm_rm,
    input  reg_idx_t  d_seg_sel,
    input  stack_op_t d_stack_op,
    input  logic      d_movs,
    input  logic      d_writes_op0,
    output logic      r_valid,
    input  logic      r_ready,
    output reg_idx_t  r_op0_reg,
    output reg_idx_t  r_op1_reg,
    output word_t     r_op0_value,
    output word_t     r_op1_value,
    output word_t     r_stack_address,
    output word_t     r_esi,
    output word_t     r_edi,
    output seg_t      r_seg_value,
    input  logic      flag_df,
    input  logic      write_cs_enable,
    input  seg_t      write_cs,
    input  logic      wb_reg_en,
    input  logic      wb_stack,
    input  reg_idx_t  wb_reg_number,
    input  opsize_e   wb_reg_size,
    input  word_t     wb_reg_data,
    input  logic      wb_seg_en,
    input  reg_idx_t  wb_seg_number,
    input  seg_t      wb_seg_data,
    input  logic      wb_stack_en,
    input  stack_op_t wb_stack_op,
    input  opsize_e   wb_stack_size
);

    // Lane order sets write priority
    localparam int LANE_WB    = 0;
    localparam int LANE_STACK = 1;
    localparam int LANE_STR   = 2;

    logic     wr_en;
    reg_idx_t wr_idx;
    opsize_e  wr_size;
    word_t    wr_data;
    word_t    esp;
    seg_t     ss;
    logic     sb_stall;
    logic     str_busy;
    logic     commit_hold;
    logic     stall;
    logic     accept;

    gpr_write_if lanes [NUM_LANES] ();

    assign r_op0_reg = (d_op0 == op_modrm_rm) ? d_modrm_rm : d_op0_reg;
    assign r_op1_reg = (d_op1 == op_modrm_rm) ? d_modrm_rm : d_op1_reg;

    assign stall   = sb_stall || str_busy || commit_hold;
    assign r_valid = d_valid && !stall;
    assign d_ready = r_ready && !stall;
    assign accept  = d_valid && d_ready;

    // Writeback is always granted, so no back-pressure toward it
    assign lanes[LANE_WB].req  = wb_reg_en;
    assign lanes[LANE_WB].idx  = wb_reg_number;
    assign lanes[LANE_WB].size = wb_reg_size;
    assign lanes[LANE_WB].data = wb_reg_data;

    gpr_write_arbiter #(
        .NUM_LANES(NUM_LANES)
    ) u_gpr_write_arbiter (
        .lanes(lanes), .wr_en(wr_en), .wr_idx(wr_idx),
        .wr_size(wr_size), .wr_data(wr_data)
    );

    gpr_file u_gpr_file (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_idx(wr_idx),
        .wr_size(wr_size), .wr_data(wr_data),
        .rd0_idx(r_op0_reg), .rd1_idx(r_op1_reg),
        .rd0_data(r_op0_value), .rd1_data(r_op1_value),
        .esp(esp), .esi(r_esi), .edi(r_edi)
    );

    seg_file u_seg_file (
        .clk(clk), .rst_n(rst_n), .wr_en(wb_seg_en), .wr_idx(wb_seg_number),
        .wr_data(wb_seg_data), .write_cs_enable(write_cs_enable), .write_cs(write_cs),
        .rd_idx(d_seg_sel), .rd_data(r_seg_value), .ss(ss)
    );

    reg_scoreboard u_reg_scoreboard (
        .clk(clk), .rst_n(rst_n), .accept(accept), .writes_op0(d_writes_op0),
        .op0_reg(r_op0_reg), .op1_reg(r_op1_reg), .size(d_size),
        .stack_use(|d_stack_op), .wb_en(wb_reg_en), .wb_idx(wb_reg_number),
        .wb_size(wb_reg_size), .stall(sb_stall)
    );

    stack_tracker u_stack_tracker (
        .clk(clk), .rst_n(rst_n), .accept(accept), .stack_op(d_stack_op),
        .size(d_size), .wb_reg_en(wb_reg_en), .wb_stack(wb_stack),
        .wb_reg_number(wb_reg_number), .wb_reg_data(wb_reg_data),
        .wb_stack_en(wb_stack_en), .wb_stack_op(wb_stack_op),
        .wb_stack_size(wb_stack_size), .esp(esp), .ss(ss),
        .commit_hold(commit_hold), .stack_address(r_stack_address),
        .commit(lanes[LANE_STACK])
    );

    string_pointer_unit u_string_pointer_unit (
        .clk(clk), .rst_n(rst_n), .start(accept && d_movs), .flag_df(flag_df),
        .size(d_size), .esi(r_esi), .edi(r_edi), .busy(str_busy),
        .lane(lanes[LANE_STR])
    );

endmodule

`default_nettype wire

// ==== tb/reg_access_clk_gen.sv ====
// Clock and reset for the register access testbench
`default_nettype none

module reg_access_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Release on a falling edge, away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/reg_access_tb.sv ====
// Testbench for the register access stage
// Reference model of registers, segments and stack pointer
// Sized writeback, stall, stack, MOVS, segment and contention tests
`default_nettype none

module reg_access_tb
    import reg_access_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 50;

    logic      clk;
    logic      rst_n;
    logic      d_valid;
    logic      d_ready;
    opsize_e   d_size;
    opkind_e   d_op0;
    opkind_e   d_op1;
    reg_idx_t  d_op0_reg;
    reg_idx_t  d_op1_reg;
    reg_idx_t  d_modrm_rm;
    reg_idx_t  d_seg_sel;
    stack_op_t d_stack_op;
    logic      d_movs;
    logic      d_writes_op0;
    logic      r_valid;
    logic      r_ready;
    reg_idx_t  r_op0_reg;
    reg_idx_t  r_op1_reg;
    word_t     r_op0_value;
    word_t     r_op1_value;
    word_t     r_stack_address;
    word_t     r_esi;
    word_t     r_edi;
    seg_t      r_seg_value;
    logic      flag_df;
    logic      write_cs_enable;
    seg_t      write_cs;
    logic      wb_reg_en;
    logic      wb_stack;
    reg_idx_t  wb_reg_number;
    opsize_e   wb_reg_size;
    word_t     wb_reg_data;
    logic      wb_seg_en;
    reg_idx_t  wb_seg_number;
    seg_t      wb_seg_data;
    logic      wb_stack_en;
    stack_op_t wb_stack_op;
    opsize_e   wb_stack_size;

    // Reference model state
    word_t       gpr_m [8];
    seg_t        seg_m [6];
    word_t       spec_esp_m;
    logic [7:0]  pending_m;
    logic [31:0] lfsr = 32'hf51f;
    int          checks;
    int          errors;
    int          test_errors;
    stack_op_t   ops_q [$];
    opsize_e     sizes_q [$];

    reg_access_clk_gen u_clk_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    reg_access_top #(
        .NUM_LANES(3)
    ) u_reg_access_top (.*);

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic opsize_e rand_size();
        logic [1:0] b;
        b = 2'(rand_bits(2));
        return (b == 2'd0) ? size_dword : opsize_e'(b);
    endfunction

    // Byte 1, word 2, dword 4
    function automatic word_t step_of(input opsize_e s);
        return 32'd1 << (int'(s) - 1);
    endfunction

    // Byte writes to 4..7 land in bits 15:8
    function automatic word_t sized_write(input word_t old, input reg_idx_t idx,
                                          input opsize_e s, input word_t data);
        case (s)
            size_dword: return data;
            size_word:  return {old[31:16], data[15:0]};
            default:    return idx[2] ? {old[31:16], data[7:0], old[7:0]}
                                      : {old[31:8], data[7:0]};
        endcase
    endfunction

    function automatic word_t stack_addr(input seg_t ss, input word_t sp,
                                         input stack_op_t op, input opsize_e s);
        if (op[1]) begin
            return word_t'(ss) + sp;
        end
        return word_t'(ss) + sp - step_of(s);
    endfunction

    function automatic word_t step_ptr(input word_t ptr, input logic df, input opsize_e s);
        return df ? ptr - step_of(s) : ptr + step_of(s);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("test %-26s ok", name);
        end else begin
            $display("test %-26s %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Returns on the falling edge after d_ready was seen high
    task automatic wait_ready(input string what);
        int n;
        n = 0;
        #1;
        while (!d_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!d_ready) begin
            $display("timed out after %0d cycles waiting for d_ready (%s)", n, what);
            errors++;
            test_errors++;
        end
        @(negedge clk);
    endtask

    task automatic issue(input string what);
        d_valid = 1'b1;
        wait_ready(what);
        d_valid = 1'b0;
    endtask

    task automatic writeback(input reg_idx_t idx, input opsize_e s, input word_t data);
        reg_idx_t tgt;
        tgt = (s == size_byte) ? {1'b0, idx[1:0]} : idx;
        wb_reg_en = 1'b1;
        wb_reg_number = idx;
        wb_reg_size = s;
        wb_reg_data = data;
        @(negedge clk);
        wb_reg_en = 1'b0;
        gpr_m[tgt] = sized_write(gpr_m[tgt], idx, s, data);
        pending_m[tgt] = 1'b0;
        if (idx == ESP_IDX) begin
            spec_esp_m = data;
        end
    endtask

    task automatic seg_writeback(input reg_idx_t idx, input seg_t data);
        wb_seg_en = 1'b1;
        wb_seg_number = idx;
        wb_seg_data = data;
        @(negedge clk);
        wb_seg_en = 1'b0;
        if (idx < 6) begin
            seg_m[idx] = data;
        end
    endtask

    task automatic check_reg(input reg_idx_t idx);
        reg_idx_t other;
        other = ~idx;
        d_op0 = op_reg;
        d_op0_reg = idx;
        d_op1 = op_modrm_rm;
        d_modrm_rm = other;
        #1;
        check_value($sformatf("gpr %0d on op0", idx), r_op0_value, gpr_m[idx]);
        check_value($sformatf("gpr %0d on op1", other), r_op1_value, gpr_m[other]);
        @(negedge clk);
    endtask

    task automatic check_seg(input reg_idx_t idx);
        seg_t exp;
        exp = (idx < 6) ? seg_m[idx] : 16'h0;
        d_seg_sel = idx;
        #1;
        check_value($sformatf("segment %0d", idx), r_seg_value, exp);
        @(negedge clk);
    endtask

    initial begin
        reg_idx_t  idx;
        reg_idx_t  tgt;
        reg_idx_t  other;
        reg_idx_t  op1_idx;
        opsize_e   size;
        stack_op_t op;
        word_t     data;
        seg_t      cs_a;
        int        n;

        {d_valid, d_movs, d_writes_op0, flag_df, write_cs_enable} = '0;
        {wb_reg_en, wb_stack, wb_seg_en, wb_stack_en} = '0;
        {d_op0_reg, d_op1_reg, d_modrm_rm, d_seg_sel, wb_reg_number, wb_seg_number} = '0;
        d_size = size_dword;
        d_op0 = op_reg;
        d_op1 = op_reg;
        d_stack_op = 2'b00;
        r_ready = 1'b1;
        write_cs = '0;
        wb_reg_size = size_dword;
        wb_reg_data = '0;
        wb_seg_data = '0;
        wb_stack_op = 2'b00;
        wb_stack_size = size_dword;
        foreach (gpr_m[i]) gpr_m[i] = '0;
        foreach (seg_m[i]) seg_m[i] = '0;
        spec_esp_m = '0;
        pending_m = '0;
        checks = 0;
        errors = 0;
        test_errors = 0;

        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
        end
        @(negedge clk);

        // Sized writeback, AH..BH first
        #1;
        check_value("r_valid after reset", r_valid, 1'b0);
        check_value("d_ready after reset", d_ready, 1'b1);
        @(negedge clk);
        for (int i = 0; i < 24; i++) begin
            idx = (i < 4) ? reg_idx_t'(4 + i) : reg_idx_t'(rand_bits(3));
            size = (i < 4) ? size_byte : rand_size();
            data = rand_bits(32);
            writeback(idx, size, data);
            tgt = (size == size_byte) ? {1'b0, idx[1:0]} : idx;
            other = reg_idx_t'(rand_bits(3));
            op1_idx = i[0] ? ~tgt : other;
            d_op0 = i[0] ? op_reg : op_modrm_rm;
            d_op0_reg = i[0] ? tgt : ~tgt;
            d_modrm_rm = i[0] ? ~tgt : tgt;
            d_op1 = i[0] ? op_modrm_rm : op_reg;
            d_op1_reg = other;
            #1;
            check_value("op0 register number", r_op0_reg, tgt);
            check_value("op1 register number", r_op1_reg, op1_idx);
            check_value("op0 value", r_op0_value, gpr_m[tgt]);
            check_value("op1 value", r_op1_value, gpr_m[op1_idx]);
            @(negedge clk);
        end
        end_test("sized writeback");

        // Read-after-write on EBX, then the same pair without a write
        for (int run = 0; run < 2; run++) begin
            d_op0 = op_reg;
            d_op1 = op_reg;
            d_op0_reg = 3'd3;
            d_op1_reg = 3'd0;
            d_writes_op0 = (run == 0);
            issue("producer accept");
            if (run == 0) begin
                pending_m[3] = 1'b1;
            end
            d_writes_op0 = 1'b0;
            d_op0_reg = 3'd1;
            d_op1_reg = 3'd3;
            d_valid = 1'b1;
            for (int c = 0; c < 3; c++) begin
                #1;
                check_value("r_valid with pending operand", r_valid,
                            !(pending_m[1] || pending_m[3]));
                @(negedge clk);
            end
            if (run == 0) begin
                writeback(3'd3, size_dword, rand_bits(32));
            end
            #1;
            check_value("r_valid after writeback", r_valid, 1'b1);
            @(negedge clk);
            d_valid = 1'b0;
        end
        end_test("read-after-write stall");

        // Stack address from speculative ESP, then commits
        seg_writeback(3'd2, 16'h0100);
        writeback(ESP_IDX, size_dword, 32'h0000_2000);
        d_op0_reg = 3'd0;
        d_op1_reg = 3'd0;
        for (int i = 0; i < 10; i++) begin
            op = rand_bits(1) ? 2'b10 : 2'b01;
            size = rand_size();
            d_stack_op = op;
            d_size = size;
            d_valid = 1'b1;
            #1;
            check_value("stack address", r_stack_address,
                        stack_addr(seg_m[2], spec_esp_m, op, size));
            wait_ready("stack instruction accept");
            d_valid = 1'b0;
            spec_esp_m = op[1] ? spec_esp_m + step_of(size) : spec_esp_m - step_of(size);
            ops_q.push_back(op);
            sizes_q.push_back(size);
        end
        d_stack_op = 2'b00;
        d_size = size_dword;
        while (ops_q.size() > 0) begin
            op = ops_q.pop_front();
            size = sizes_q.pop_front();
            wb_stack_en = 1'b1;
            wb_stack_op = op;
            wb_stack_size = size;
            @(negedge clk);
            wb_stack_en = 1'b0;
            // Commit lane writes on the following edge
            @(negedge clk);
            gpr_m[ESP_IDX] = op[1] ? gpr_m[ESP_IDX] + step_of(size)
                                   : gpr_m[ESP_IDX] - step_of(size);
            check_reg(ESP_IDX);
        end
        end_test("stack address and commit");

        // MOVS with both DF values and every size
        writeback(ESI_IDX, size_dword, rand_bits(32));
        writeback(EDI_IDX, size_dword, rand_bits(32));
        for (int df = 0; df < 2; df++) begin
            for (int s = 1; s < 4; s++) begin
                size = opsize_e'(s);
                flag_df = df[0];
                d_size = size;
                d_movs = 1'b1;
                issue("movs accept");
                d_movs = 1'b0;
                #1;
                check_value("d_ready while movs busy", d_ready, 1'b0);
                wait_ready("movs pointer writes");
                gpr_m[ESI_IDX] = step_ptr(gpr_m[ESI_IDX], df[0], size);
                gpr_m[EDI_IDX] = step_ptr(gpr_m[EDI_IDX], df[0], size);
                check_value("esi after movs", r_esi, gpr_m[ESI_IDX]);
                check_value("edi after movs", r_edi, gpr_m[EDI_IDX]);
            end
        end
        end_test("movs pointer step");

        // Segment writeback, direct CS write, CS conflict
        for (int i = 0; i < 6; i++) begin
            seg_writeback(reg_idx_t'(i), seg_t'(rand_bits(16)));
        end
        for (int i = 0; i < 8; i++) begin
            check_seg(reg_idx_t'(i));
        end
        write_cs_enable = 1'b1;
        write_cs = seg_t'(rand_bits(16));
        @(negedge clk);
        write_cs_enable = 1'b0;
        seg_m[1] = write_cs;
        check_seg(3'd1);
        cs_a = seg_t'(rand_bits(16));
        wb_seg_en = 1'b1;
        wb_seg_number = 3'd1;
        wb_seg_data = cs_a;
        write_cs_enable = 1'b1;
        write_cs = ~cs_a;
        @(negedge clk);
        wb_seg_en = 1'b0;
        write_cs_enable = 1'b0;
        seg_m[1] = ~cs_a;
        check_seg(3'd1);
        end_test("segment writes");

        // Writeback beats a stack commit in the same cycle
        wb_stack_en = 1'b1;
        wb_stack_op = 2'b01;
        wb_stack_size = size_dword;
        @(negedge clk);
        wb_stack_en = 1'b0;
        data = rand_bits(32);
        wb_reg_en = 1'b1;
        wb_reg_number = 3'd2;
        wb_reg_size = size_dword;
        wb_reg_data = data;
        #1;
        check_value("d_ready while commit held", d_ready, 1'b0);
        @(negedge clk);
        wb_reg_en = 1'b0;
        gpr_m[2] = data;
        wait_ready("held stack commit");
        gpr_m[ESP_IDX] = gpr_m[ESP_IDX] - step_of(size_dword);

        // Writebacks while MOVS waits for the port
        flag_df = 1'b0;
        d_size = size_word;
        d_movs = 1'b1;
        issue("movs accept under contention");
        d_movs = 1'b0;
        for (int i = 0; i < 3; i++) begin
            data = rand_bits(32);
            wb_reg_en = 1'b1;
            wb_reg_number = 3'd1;
            wb_reg_size = size_dword;
            wb_reg_data = data;
            #1;
            check_value("d_ready during contended movs", d_ready, 1'b0);
            @(negedge clk);
            gpr_m[1] = data;
        end
        wb_reg_en = 1'b0;
        wait_ready("contended movs pointer writes");
        gpr_m[ESI_IDX] = step_ptr(gpr_m[ESI_IDX], 1'b0, size_word);
        gpr_m[EDI_IDX] = step_ptr(gpr_m[EDI_IDX], 1'b0, size_word);
        for (int i = 0; i < 8; i++) begin
            check_reg(reg_idx_t'(i));
        end
        end_test("write port contention");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== reg_access.f ====
logic/reg_access_pkg.sv
logic/gpr_write_if.sv
logic/gpr_write_arbiter.sv
logic/gpr_file.sv
logic/seg_file.sv
logic/reg_scoreboard.sv
logic/stack_tracker.sv
logic/string_pointer_unit.sv
logic/reg_access_top.sv
tb/reg_access_clk_gen.sv
tb/reg_access_tb.sv

// ==== Bender.yml ====
package:
  name: reg_access

sources:
  - files:
      - logic/reg_access_pkg.sv
      - logic/gpr_write_if.sv
      - logic/gpr_write_arbiter.sv
      - logic/gpr_file.sv
      - logic/seg_file.sv
      - logic/reg_scoreboard.sv
      - logic/stack_tracker.sv
      - logic/string_pointer_unit.sv
      - logic/reg_access_top.sv
  - target: test
    files:
      - tb/reg_access_clk_gen.sv
      - tb/reg_access_tb.sv
